// File: verilog.f
+incdir+include
src/exe_ops_pkg.sv
src/exe_pipe_pkg.sv
src/stage_reg.sv
src/alu.sv
src/store_align.sv
src/addr_check.sv
src/exe_stage.sv
src/exe_top.sv
testbench/exe_ref_pkg.sv
testbench/exe_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary -j 0
TOP      = exe_tb
FILELIST = verilog.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)

// File: testbench/exe_tb.sv
`timescale 1ns/10ps
`include "exe_settings.svh"

module exe_tb;
    import exe_ops_pkg::*;
    import exe_pipe_pkg::*;
    import exe_ref_pkg::*;

    logic        clk = 1'b0;
    logic        reset;
    logic        flush;
    logic        id_valid;
    logic        id_ready;
    id_to_exe_t  id_data;
    logic        mem_valid;
    logic        mem_ready;
    exe_to_mem_t mem_data;
    dm_write_t   dm_write;

    exe_to_mem_t exp_mem[$];      // expected records, oldest first
    dm_write_t   exp_dm[$];
    dm_write_t   pending_write;
    string       test_name = "reset";
    int          ready_mode;      // 0 always ready, 1 random, 2 stalled
    logic        ready_coin = 1'b1;
    logic        took_input = 1'b0;
    logic [`EXE_XLEN-1:0] next_pc;
    int          issued;
    int          cycles;
    int          tests;
    int          checks;
    int          errors;
    int          flow_errors;
    int          first_checks;
    int          first_errors;
    logic [`EXE_XLEN-1:0] ovf_a [4] = '{32'h7fff_ffff, 32'h8000_0000,
                                        32'h8000_0000, 32'h7fff_ffff};
    logic [`EXE_XLEN-1:0] ovf_b [4] = '{32'h0000_0001, 32'hffff_ffff,
                                        32'h0000_0001, 32'hffff_ffff};

    exe_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .id_valid  (id_valid),
        .id_ready  (id_ready),
        .id_data   (id_data),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_data  (mem_data),
        .dm_write  (dm_write)
    );

    always #5 clk = ~clk;

    always @(negedge clk) ready_coin <= ($urandom % 4) != 0;
    assign mem_ready = (ready_mode == 0) || (ready_mode == 1 && ready_coin);

    // ------------------------------------------------------------
    // compare tasks and scoreboard
    // ------------------------------------------------------------
    task automatic report_error(input string what);
        $display("[ERROR] %s: %s", test_name, what);
        errors++;
    endtask

    task automatic check_mem(input exe_to_mem_t exp, input exe_to_mem_t act);
        checks++;
        if (act !== exp) begin
            $display("[FAIL] %s: record expected %h, actual %h", test_name, exp, act);
            errors++;
        end
    endtask

    task automatic check_dm(input dm_write_t exp, input dm_write_t act);
        checks++;
        if (act !== exp) begin
            $display("[FAIL] %s: write expected %h, actual %h", test_name, exp, act);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        took_input <= 1'b0;
        if (!reset) begin
            if (mem_valid && mem_ready) begin
                if (exp_mem.size() == 0) begin
                    report_error("a record left the memory stage with none expected");
                end else begin
                    check_mem(exp_mem.pop_front(), mem_data);
                end
            end
            if (dm_write.we != 4'b0000) begin
                if (flush || exp_dm.size() == 0) begin
                    report_error("a memory write appeared with none expected");
                end else begin
                    check_dm(exp_dm.pop_front(), dm_write);
                end
            end
            if (flush) begin
                exp_mem.delete();  // every record in flight is dropped
                exp_dm.delete();
            end else if (id_valid && id_ready) begin
                exp_mem.push_back(expected_result(id_data));
                pending_write = expected_write(id_data);
                if (pending_write.we != 4'b0000) begin
                    exp_dm.push_back(pending_write);
                end
                took_input <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 20 * issued + 200) begin
            $display("timeout after %0d cycles, %0d records and %0d writes still expected",
                     cycles, exp_mem.size(), exp_dm.size());
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic issue(input id_to_exe_t d);
        id_data  = d;
        id_valid = 1'b1;
        issued++;
        do begin
            @(negedge clk);
        end while (!took_input);
        id_valid = 1'b0;
    endtask

    task automatic send(input alu_op_e op, input logic [`EXE_XLEN-1:0] a,
                        input logic [`EXE_XLEN-1:0] b, input mem_op_e mop = MEM_NONE,
                        input logic [`EXE_XLEN-1:0] sdata = '0, input logic exc_in = 1'b0,
                        input logic [`EXE_XLEN-1:0] vaddr = '0);
        id_to_exe_t d;
        d.pc           = next_pc;
        d.alu_op       = op;
        d.src_a        = a;
        d.src_b        = b;
        d.store_data   = sdata;
        d.mem_op       = mop;
        d.dest         = 5'($urandom);
        d.in_exc       = exc_in;
        d.in_exc_code  = exc_in ? EXC_ADEL : EXC_NONE;  // fetch fault from upstream
        d.in_bad_vaddr = vaddr;
        next_pc        = next_pc + 4;
        issue(d);
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        first_checks = checks;
        first_errors = errors + flow_errors;
    endtask

    task automatic finish_test();
        while (exp_mem.size() != 0 || exp_dm.size() != 0) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);  // room for stray outputs
        tests++;
        $display("test %s: %0d checks, %0d errors", test_name, checks - first_checks,
                 errors + flow_errors - first_errors);
    endtask

    initial begin
        logic [`EXE_XLEN-1:0] base;
        void'($urandom(32'h43a2));
        reset      = 1'b1;
        flush      = 1'b0;
        id_valid   = 1'b0;
        id_data    = '0;
        ready_mode = 0;
        next_pc    = `EXE_RESET_PC;
        base       = $urandom & ~32'h3;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        if (mem_valid || !id_ready || dm_write.we != 4'b0000) begin
            $display("[ERROR] reset: outputs are not idle after reset");
            flow_errors++;
        end

        start_test("alu_ops");
        for (int k = 0; k < 14; k++) begin
            send(alu_op_e'(4'(k)), 32'd5, 32'd3);
            send(alu_op_e'(4'(k)), 32'h0000_0024, 32'h8000_1234);
            send(alu_op_e'(4'(k)), 32'hffff_fff0, 32'h0000_0007);
            repeat (4) send(alu_op_e'(4'(k)), $urandom, $urandom);
        end
        finish_test();

        start_test("overflow");
        foreach (ovf_a[i]) begin
            send(ALU_ADD, ovf_a[i], ovf_b[i]);
            send(ALU_ADDU, ovf_a[i], ovf_b[i]);
            send(ALU_SUB, ovf_a[i], ovf_b[i]);
            send(ALU_SUBU, ovf_a[i], ovf_b[i]);
        end
        finish_test();

        ready_mode = 1;  // back-pressure from here on
        start_test("store_sb_sh_sw");
        for (int off = 0; off < 4; off++) begin
            send(ALU_ADDU, base, off, MEM_SB, $urandom);
            if (off % 2 == 0) begin
                send(ALU_ADDU, base, off, MEM_SH, $urandom);
            end
            if (off == 0) begin
                send(ALU_ADDU, base, off, MEM_SW, $urandom);
            end
        end
        finish_test();

        start_test("store_swl_swr");
        for (int off = 0; off < 4; off++) begin
            send(ALU_ADDU, base, off, MEM_SWL, $urandom);
            send(ALU_ADDU, base, off, MEM_SWR, $urandom);
        end
        finish_test();

        start_test("misaligned");
        for (int off = 1; off < 4; off++) begin
            send(ALU_ADDU, base, off, MEM_LW);
            send(ALU_ADDU, base, off, MEM_SW, $urandom);
            if (off != 2) begin
                send(ALU_ADDU, base, off, MEM_LH);
                send(ALU_ADDU, base, off, MEM_SH, $urandom);
            end
            send(ALU_ADDU, base, off, MEM_SW, $urandom, 1'b1, $urandom);  // upstream wins
        end
        finish_test();

        start_test("backpressure");
        repeat (150) send(alu_op_e'(4'($urandom % 14)), $urandom, $urandom,
                          mem_op_e'(4'($urandom % 13)), $urandom);
        finish_test();

        // two stores in flight behind a stalled memory stage
        start_test("flush");
        ready_mode = 2;
        send(ALU_ADDU, base, 32'd0, MEM_SW, $urandom);
        send(ALU_ADDU, base, 32'd4, MEM_SW, $urandom);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        if (mem_valid) begin
            $display("[ERROR] flush: a record is still valid after the flush");
            flow_errors++;
        end

        // store ready to hand off while flush is up, its write must not go out
        send(ALU_ADDU, base, 32'd8);
        send(ALU_ADDU, base, 32'd12, MEM_SW, $urandom);
        ready_mode = 0;
        flush      = 1'b1;
        @(negedge clk);
        flush      = 1'b0;
        ready_mode = 1;
        if (mem_valid) begin
            $display("[ERROR] flush: a store moved into the memory stage during the flush");
            flow_errors++;
        end
        repeat (10) @(negedge clk);
        repeat (4) send(ALU_ADDU, base, 32'd8, MEM_SB, $urandom);
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors + flow_errors);
        if (errors + flow_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/exe_ref_pkg.sv
`include "exe_settings.svh"

package exe_ref_pkg;
    import exe_ops_pkg::*;
    import exe_pipe_pkg::*;

    localparam int XLEN = `EXE_XLEN;

    // ------------------------------------------------------------
    // instruction level model of the execute stage
    // ------------------------------------------------------------
    function automatic logic [XLEN-1:0] alu_value(alu_op_e op, logic [XLEN-1:0] a,
                                                  logic [XLEN-1:0] b);
        case (op)
            ALU_ADD, ALU_ADDU: return a + b;
            ALU_SUB, ALU_SUBU: return a + ~b + XLEN'(1);  // two's complement subtract
            ALU_AND:           return a & b;
            ALU_OR:            return a | b;
            ALU_XOR:           return a ^ b;
            ALU_NOR:           return ~a & ~b;
            ALU_SLT:           return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU:          return {{(XLEN-1){1'b0}}, a < b};
            ALU_SLL:           return b << a[4:0];
            ALU_SRL:           return b >> a[4:0];
            ALU_SRA:           return $signed(b) >>> a[4:0];
            ALU_LUI:           return {b[15:0], 16'h0000};
            default:           return '0;
        endcase
    endfunction

    // one extra sign bit, overflow when the top two bits disagree
    function automatic logic signed_overflow(alu_op_e op, logic [XLEN-1:0] a,
                                             logic [XLEN-1:0] b);
        logic [XLEN:0] wide;
        if (op == ALU_ADD) begin
            wide = {a[XLEN-1], a} + {b[XLEN-1], b};
        end else if (op == ALU_SUB) begin
            wide = {a[XLEN-1], a} - {b[XLEN-1], b};
        end else begin
            return 1'b0;
        end
        return wide[XLEN] != wide[XLEN-1];
    endfunction

    function automatic logic writes_memory(mem_op_e op);
        return op == MEM_SB || op == MEM_SH || op == MEM_SW || op == MEM_SWL || op == MEM_SWR;
    endfunction

    function automatic logic bad_alignment(mem_op_e op, logic [XLEN-1:0] addr);
        case (op)
            MEM_LH, MEM_LHU, MEM_SH: return addr[0] != 1'b0;
            MEM_LW, MEM_SW:          return addr[1:0] != 2'b00;
            default:                 return 1'b0;
        endcase
    endfunction

    function automatic exe_to_mem_t expected_result(id_to_exe_t d);
        exe_to_mem_t r;
        r.pc        = d.pc;
        r.result    = alu_value(d.alu_op, d.src_a, d.src_b);
        r.mem_op    = d.mem_op;
        r.dest      = d.dest;
        r.bad_vaddr = d.in_exc ? d.in_bad_vaddr : r.result;
        r.exc       = 1'b1;
        if (d.in_exc) begin
            r.exc_code = d.in_exc_code;
        end else if (signed_overflow(d.alu_op, d.src_a, d.src_b)) begin
            r.exc_code = EXC_OV;
        end else if (bad_alignment(d.mem_op, r.result)) begin
            r.exc_code = writes_memory(d.mem_op) ? EXC_ADES : EXC_ADEL;
        end else begin
            r.exc      = 1'b0;
            r.exc_code = EXC_NONE;
        end
        return r;
    endfunction

    // byte lanes are little endian, lane 0 at the word address
    function automatic dm_write_t expected_write(id_to_exe_t d);
        dm_write_t   w;
        exe_to_mem_t r;
        int          off;
        r      = expected_result(d);
        off    = int'(r.result[1:0]);
        w.addr = {r.result[XLEN-1:2], 2'b00};
        w.data = '0;
        w.we   = 4'b0000;
        if (!r.exc) begin
            case (d.mem_op)
                MEM_SB: begin
                    w.data = {4{d.store_data[7:0]}};
                    w.we   = 4'b0001 << off;
                end
                MEM_SH: begin
                    w.data = {2{d.store_data[15:0]}};
                    w.we   = (off >= 2) ? 4'b1100 : 4'b0011;
                end
                MEM_SW: begin
                    w.data = d.store_data;
                    w.we   = 4'b1111;
                end
                MEM_SWL: begin
                    w.data = d.store_data >> (8 * (3 - off));
                    for (int i = 0; i <= off; i++) begin
                        w.we = w.we | (4'b0001 << i);
                    end
                end
                MEM_SWR: begin
                    w.data = d.store_data << (8 * off);
                    for (int i = off; i < 4; i++) begin
                        w.we = w.we | (4'b0001 << i);
                    end
                end
                default: w.we = 4'b0000;  // loads and plain alu ops
            endcase
        end
        return w;
    endfunction

endpackage

// File: src/exe_top.sv
`timescale 1ns/10ps

module exe_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       id_valid,
    output logic                       id_ready,
    input  exe_pipe_pkg::id_to_exe_t   id_data,
    output logic                       mem_valid,
    input  logic                       mem_ready,
    output exe_pipe_pkg::exe_to_mem_t  mem_data,
    output exe_pipe_pkg::dm_write_t    dm_write
);
    import exe_pipe_pkg::*;

    logic        exe_valid;
    exe_to_mem_t exe_data;
    logic        mem_allowin;

    // ------------------------------------------------------------
    // execute, then the memory stage register
    // ------------------------------------------------------------
    exe_stage i_exe_stage (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .id_valid    (id_valid),
        .exe_allowin (id_ready),
        .id_data     (id_data),
        .mem_allowin (mem_allowin),
        .exe_valid   (exe_valid),
        .exe_data    (exe_data),
        .dm_write    (dm_write)
    );

    stage_reg #(.payload_t(exe_to_mem_t)) i_mem_reg (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .in_valid   (exe_valid),
        .in_allowin (mem_allowin),
        .in_data    (exe_data),
        .out_valid  (mem_valid),
        .out_ready  (mem_ready),
        .out_data   (mem_data)
    );

endmodule

// File: src/exe_stage.sv
`timescale 1ns/10ps
`include "exe_settings.svh"

module exe_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  logic                       id_valid,
    output logic                       exe_allowin,
    input  exe_pipe_pkg::id_to_exe_t   id_data,
    input  logic                       mem_allowin,
    output logic                       exe_valid,
    output exe_pipe_pkg::exe_to_mem_t  exe_data,
    output exe_pipe_pkg::dm_write_t    dm_write
);
    import exe_ops_pkg::*;
    import exe_pipe_pkg::*;

    id_to_exe_t           rec;          // held instruction
    logic                 rec_valid;
    logic [`EXE_XLEN-1:0] alu_result;
    logic                 alu_ovf;
    logic [`EXE_XLEN-1:0] lane_data;
    logic [3:0]           byte_en;
    logic                 addr_exc;
    exc_code_e            addr_code;
    logic                 moving;

    // ------------------------------------------------------------
    // input register and datapath
    // ------------------------------------------------------------
    stage_reg #(.payload_t(id_to_exe_t)) i_in_reg (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .in_valid   (id_valid),
        .in_allowin (exe_allowin),
        .in_data    (id_data),
        .out_valid  (rec_valid),
        .out_ready  (mem_allowin),
        .out_data   (rec)
    );

    alu i_alu (
        .op       (rec.alu_op),
        .a        (rec.src_a),
        .b        (rec.src_b),
        .result   (alu_result),
        .overflow (alu_ovf)
    );

    store_align i_store_align (
        .mem_op     (rec.mem_op),
        .offset     (alu_result[1:0]),
        .store_data (rec.store_data),
        .lane_data  (lane_data),
        .byte_en    (byte_en)
    );

    addr_check i_addr_check (
        .mem_op   (rec.mem_op),
        .addr     (alu_result),
        .exc      (addr_exc),
        .exc_code (addr_code)
    );

    // ------------------------------------------------------------
    // result record
    // ------------------------------------------------------------
    always_comb begin
        exe_data.pc     = rec_valid ? rec.pc : `EXE_RESET_PC;  // empty slot shows boot pc
        exe_data.result = alu_result;
        exe_data.mem_op = rec.mem_op;
        exe_data.dest   = rec.dest;
        exe_data.bad_vaddr = rec.in_exc ? rec.in_bad_vaddr : alu_result;
        if (rec.in_exc) begin           // earlier stage has priority
            exe_data.exc      = 1'b1;
            exe_data.exc_code = rec.in_exc_code;
        end else if (alu_ovf) begin
            exe_data.exc      = 1'b1;
            exe_data.exc_code = EXC_OV;
        end else if (addr_exc) begin
            exe_data.exc      = 1'b1;
            exe_data.exc_code = addr_code;
        end else begin
            exe_data.exc      = 1'b0;
            exe_data.exc_code = EXC_NONE;
        end
    end

    assign exe_valid = rec_valid;

    // write only on the handoff edge, so a stalled store goes out once
    assign moving = rec_valid && mem_allowin && !flush;

    assign dm_write.we   = (moving && !exe_data.exc) ? byte_en : 4'b0000;
    assign dm_write.addr = {alu_result[`EXE_XLEN-1:2], 2'b00};
    assign dm_write.data = lane_data;

endmodule

// File: src/addr_check.sv
`timescale 1ns/10ps
`include "exe_settings.svh"

module addr_check (
    input  exe_ops_pkg::mem_op_e    mem_op,
    input  logic [`EXE_XLEN-1:0]    addr,
    output logic                    exc,
    output exe_ops_pkg::exc_code_e  exc_code
);
    import exe_ops_pkg::*;

    logic misaligned;

    always_comb begin
        case (mem_op)
            MEM_LH, MEM_LHU, MEM_SH: misaligned = addr[0];
            MEM_LW, MEM_SW:          misaligned = |addr[1:0];
            default:                 misaligned = 1'b0;  // bytes and lwl/lwr/swl/swr
        endcase
    end

    assign exc = misaligned;

    always_comb begin
        if (!misaligned) begin
            exc_code = EXC_NONE;
        end else if (is_store(mem_op)) begin
            exc_code = EXC_ADES;
        end else begin
            exc_code = EXC_ADEL;
        end
    end

endmodule

// File: src/store_align.sv
`timescale 1ns/10ps
`include "exe_settings.svh"

module store_align (
    input  exe_ops_pkg::mem_op_e    mem_op,
    input  logic [1:0]              offset,      // low address bits
    input  logic [`EXE_XLEN-1:0]    store_data,
    output logic [`EXE_XLEN-1:0]    lane_data,
    output logic [3:0]              byte_en
);
    import exe_ops_pkg::*;

    logic [1:0] inv_offset;
    logic [4:0] left_bits;
    logic [4:0] right_bits;

    // 3 - offset, lanes above the addressed byte
    assign inv_offset = ~offset;
    assign left_bits  = {offset, 3'b000};
    assign right_bits = {inv_offset, 3'b000};

    // ------------------------------------------------------------
    // little endian lane steering
    // ------------------------------------------------------------
    always_comb begin
        lane_data = '0;
        byte_en   = 4'b0000;
        case (mem_op)
            MEM_SB: begin
                lane_data = {4{store_data[7:0]}};
                byte_en   = 4'b0001 << offset;
            end
            MEM_SH: begin
                lane_data = {2{store_data[15:0]}};
                byte_en   = offset[1] ? 4'b1100 : 4'b0011;
            end
            MEM_SW: begin
                lane_data = store_data;
                byte_en   = 4'b1111;
            end
            MEM_SWL: begin
                // upper part of rt into lanes 0..offset
                lane_data = store_data >> right_bits;
                byte_en   = 4'b1111 >> inv_offset;
            end
            MEM_SWR: begin
                // lower part of rt into lanes offset..3
                lane_data = store_data << left_bits;
                byte_en   = 4'b1111 << offset;
            end
            default: begin
                lane_data = '0;  // loads and alu ops write nothing
                byte_en   = 4'b0000;
            end
        endcase
    end

endmodule

// File: src/alu.sv
`timescale 1ns/10ps
`include "exe_settings.svh"

module alu (
    input  exe_ops_pkg::alu_op_e    op,
    input  logic [`EXE_XLEN-1:0]    a,
    input  logic [`EXE_XLEN-1:0]    b,
    output logic [`EXE_XLEN-1:0]    result,
    output logic                    overflow
);
    import exe_ops_pkg::*;

    localparam int MSB = `EXE_XLEN - 1;

    logic [`EXE_XLEN-1:0] sum;
    logic [`EXE_XLEN-1:0] diff;
    logic [4:0]           shamt;
    logic                 add_ovf;
    logic                 sub_ovf;

    assign sum   = a + b;
    assign diff  = a - b;
    assign shamt = a[4:0];  // shift amount sits in src_a

    // same signs in, different sign out
    assign add_ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
    // signs differ and result follows b
    assign sub_ovf = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

    always_comb begin
        result = '0;
        case (op)
            ALU_ADD, ALU_ADDU: result = sum;
            ALU_SUB, ALU_SUBU: result = diff;
            ALU_AND:           result = a & b;
            ALU_OR:            result = a | b;
            ALU_XOR:           result = a ^ b;
            ALU_NOR:           result = ~(a | b);
            ALU_SLT:           result[0] = $signed(a) < $signed(b);
            ALU_SLTU:          result[0] = a < b;
            ALU_SLL:           result = b << shamt;
            ALU_SRL:           result = b >> shamt;
            ALU_SRA:           result = $signed(b) >>> shamt;
            ALU_LUI:           result = b << 16;
            default:           result = '0;
        endcase
    end

    // only the trapping forms report it
    always_comb begin
        case (op)
            ALU_ADD: overflow = add_ovf;
            ALU_SUB: overflow = sub_ovf;
            default: overflow = 1'b0;
        endcase
    end

endmodule

// File: src/stage_reg.sv
`timescale 1ns/10ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_allowin,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // empty, or the held record leaves this cycle
    assign in_allowin = !valid_q || out_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_q <= 1'b0;  // flush wins over a new record
        end else if (in_allowin) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_allowin && in_valid) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

// File: src/exe_pipe_pkg.sv
`include "exe_settings.svh"

package exe_pipe_pkg;

    // ------------------------------------------------------------
    // decode -> execute
    // ------------------------------------------------------------
    typedef struct packed {
        logic [`EXE_XLEN-1:0]     pc;
        exe_ops_pkg::alu_op_e     alu_op;
        logic [`EXE_XLEN-1:0]     src_a;         // rs, or shift amount
        logic [`EXE_XLEN-1:0]     src_b;         // rt or immediate
        logic [`EXE_XLEN-1:0]     store_data;    // rt value for stores
        exe_ops_pkg::mem_op_e     mem_op;
        logic [`EXE_REG_W-1:0]    dest;
        logic                     in_exc;        // raised in fetch or decode
        exe_ops_pkg::exc_code_e   in_exc_code;
        logic [`EXE_XLEN-1:0]     in_bad_vaddr;
    } id_to_exe_t;

    // ------------------------------------------------------------
    // execute -> memory
    // ------------------------------------------------------------
    typedef struct packed {
        logic [`EXE_XLEN-1:0]     pc;
        logic [`EXE_XLEN-1:0]     result;        // also the data address
        exe_ops_pkg::mem_op_e     mem_op;
        logic [`EXE_REG_W-1:0]    dest;
        logic                     exc;
        exe_ops_pkg::exc_code_e   exc_code;
        logic [`EXE_XLEN-1:0]     bad_vaddr;
    } exe_to_mem_t;

    // data memory write port
    typedef struct packed {
        logic [3:0]               we;            // one bit per byte lane
        logic [`EXE_XLEN-1:0]     addr;          // word aligned
        logic [`EXE_XLEN-1:0]     data;
    } dm_write_t;

endpackage

// File: src/exe_ops_pkg.sv
package exe_ops_pkg;

    // ------------------------------------------------------------
    // alu operations
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,  // traps on signed overflow
        ALU_ADDU = 4'd1,
        ALU_SUB  = 4'd2,  // traps on signed overflow
        ALU_SUBU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_SLL  = 4'd10,
        ALU_SRL  = 4'd11,
        ALU_SRA  = 4'd12,
        ALU_LUI  = 4'd13
    } alu_op_e;

    // ------------------------------------------------------------
    // memory operations
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LBU  = 4'd2,
        MEM_LH   = 4'd3,
        MEM_LHU  = 4'd4,
        MEM_LW   = 4'd5,
        MEM_LWL  = 4'd6,
        MEM_LWR  = 4'd7,
        MEM_SB   = 4'd8,  // stores from here up
        MEM_SH   = 4'd9,
        MEM_SW   = 4'd10,
        MEM_SWL  = 4'd11,
        MEM_SWR  = 4'd12
    } mem_op_e;

    // exception codes, cp0 cause encoding
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,   // load or fetch address error
        EXC_ADES = 5'd5,   // store address error
        EXC_OV   = 5'd12   // arithmetic overflow
    } exc_code_e;

    function automatic logic is_store(mem_op_e op);
        return op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SWL, MEM_SWR};
    endfunction

endpackage

// File: include/exe_settings.svh
`ifndef EXE_SETTINGS_SVH
`define EXE_SETTINGS_SVH

// ------------------------------------------------------------
// datapath sizing
// ------------------------------------------------------------

// data and address width
`define EXE_XLEN 32

// register number width, 32 gprs
`define EXE_REG_W 5

// ------------------------------------------------------------
// empty record contents
// ------------------------------------------------------------

// boot vector, shown by an empty slot
`define EXE_RESET_PC 32'hbfc0_0000

`endif
